//--- dmmu_pkg.sv
// Shared widths, SPR map and TLB entry layout for the data MMU
// Direct-mapped DTLB, one way, 64 sets, 8 KB pages
// SPR ranges follow the DTLB way-0 match/translate register map
`default_nettype none

package dmmu_pkg;

   // Datapath widths
   localparam int OPERAND_WIDTH = 32;
   localparam int SET_WIDTH     = 6;    // 64 sets
   localparam int PAGE_BITS     = 13;   // 8 KB page offset

   // Width-carrying vector types
   typedef logic [OPERAND_WIDTH-1:0]           word_t;
   typedef logic [15:0]                        spr_addr_t;
   typedef logic [SET_WIDTH-1:0]               set_idx_t;
   typedef logic [OPERAND_WIDTH-PAGE_BITS-1:0] page_num_t;  // vaddr[31:13]

   // DTLB SPR window
   localparam spr_addr_t SPR_DTLB_MR_BASE = 16'h0A00;  // Match registers
   localparam spr_addr_t SPR_DTLB_TR_BASE = 16'h0A80;  // Translate registers
   localparam spr_addr_t SPR_DTLB_END     = 16'h0B00;  // First address past the window

   // Match entry: VPN in [31:13], valid flag at bit 0
   localparam int MR_VALID_BIT = 0;

   // Translate entry: PPN in [31:13], attributes and permissions below
   localparam int TR_CI_BIT  = 1;   // Cache inhibit
   localparam int TR_URE_BIT = 6;   // User read enable
   localparam int TR_UWE_BIT = 7;   // User write enable
   localparam int TR_SRE_BIT = 8;   // Supervisor read enable
   localparam int TR_SWE_BIT = 9;   // Supervisor write enable

   // Exception cause reported with each translation
   // Miss outranks page fault
   typedef enum logic [1:0] {
      EXC_NONE       = 2'd0,
      EXC_TLB_MISS   = 2'd1,
      EXC_PAGE_FAULT = 2'd2
   } exc_t;

endpackage

`default_nettype wire

//--- tlb_ram.sv
// Single-port RAM, registered read, no write bypass
// A write cycle returns the previous contents on rdata_o
// Contents are not reset
`timescale 1ns/1ps
`default_nettype none

module tlb_ram #(
   parameter int DATA_WIDTH = dmmu_pkg::OPERAND_WIDTH,
   parameter int ADDR_WIDTH = dmmu_pkg::SET_WIDTH
) (
   input  wire logic                  clk,
   input  wire logic [ADDR_WIDTH-1:0] addr_i,
   input  wire logic                  we_i,
   input  wire logic [DATA_WIDTH-1:0] wdata_i,
   output logic      [DATA_WIDTH-1:0] rdata_o
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   logic [DATA_WIDTH-1:0] mem [DEPTH];  // Storage array

   // Read and write share one address
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];  // Old value on a write
   end

endmodule

`default_nettype wire

//--- dmmu.sv
// Data MMU, direct-mapped DTLB with SPR fill and read-back
// SPR access takes the RAM address port, so no lookup may be issued
// while a DTLB strobe is held
// Results are for match_vaddr_i, one cycle after lookup_vaddr_i
// Out-of-window strobes are never acknowledged
`timescale 1ns/1ps
`default_nettype none

module dmmu (
   input  wire logic                 clk,
   input  wire logic                 rst,
   // Lookup side
   input  wire dmmu_pkg::word_t      lookup_vaddr_i,  // RAM index source
   input  wire dmmu_pkg::word_t      match_vaddr_i,   // Address under compare
   input  wire logic                 load_i,
   input  wire logic                 store_i,
   input  wire logic                 super_i,
   output dmmu_pkg::word_t           paddr_o,
   output logic                      ci_o,
   output logic                      tlb_miss_o,
   output logic                      page_fault_o,
   // SPR bus
   input  wire logic                 spr_stb_i,
   input  wire logic                 spr_we_i,
   input  wire dmmu_pkg::spr_addr_t  spr_addr_i,
   input  wire dmmu_pkg::word_t      spr_wdata_i,
   output dmmu_pkg::word_t           spr_rdata_o,
   output logic                      spr_ack_o
);

   import dmmu_pkg::*;

   logic      match_cs;     // Strobe hits match window
   logic      xlate_cs;     // Strobe hits translate window
   logic      match_sel_q;  // Read-back mux select, aligned with RAM data
   logic      ack_q;
   set_idx_t  lookup_set;
   set_idx_t  match_addr;
   set_idx_t  xlate_addr;
   word_t     match_rdata;
   word_t     xlate_rdata;
   page_num_t match_vpn;
   page_num_t req_vpn;
   logic      rd_ok;
   logic      wr_ok;

   // Window decode
   assign match_cs = spr_stb_i &&
                     (spr_addr_i >= SPR_DTLB_MR_BASE) && (spr_addr_i < SPR_DTLB_TR_BASE);
   assign xlate_cs = spr_stb_i &&
                     (spr_addr_i >= SPR_DTLB_TR_BASE) && (spr_addr_i < SPR_DTLB_END);

   // Set index from vaddr[18:13]
   assign lookup_set = lookup_vaddr_i[PAGE_BITS +: SET_WIDTH];

   // SPR wins the address port while selected
   assign match_addr = match_cs ? spr_addr_i[SET_WIDTH-1:0] : lookup_set;
   assign xlate_addr = xlate_cs ? spr_addr_i[SET_WIDTH-1:0] : lookup_set;

   tlb_ram #(
      .DATA_WIDTH (OPERAND_WIDTH),
      .ADDR_WIDTH (SET_WIDTH)
   ) match_ram (
      .clk     (clk),
      .addr_i  (match_addr),
      .we_i    (match_cs && spr_we_i),
      .wdata_i (spr_wdata_i),
      .rdata_o (match_rdata)
   );

   tlb_ram #(
      .DATA_WIDTH (OPERAND_WIDTH),
      .ADDR_WIDTH (SET_WIDTH)
   ) xlate_ram (
      .clk     (clk),
      .addr_i  (xlate_addr),
      .we_i    (xlate_cs && spr_we_i),
      .wdata_i (spr_wdata_i),
      .rdata_o (xlate_rdata)
   );

   // Ack in second strobe cycle, one pulse per access
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q       <= 1'b0;
         match_sel_q <= 1'b0;
      end else begin
         ack_q       <= (match_cs || xlate_cs) && !ack_q;
         match_sel_q <= match_cs;
      end
   end

   assign spr_ack_o   = ack_q;
   assign spr_rdata_o = match_sel_q ? match_rdata : xlate_rdata;  // Valid with ack

   // Tag compare
   assign match_vpn  = match_rdata[OPERAND_WIDTH-1:PAGE_BITS];
   assign req_vpn    = match_vaddr_i[OPERAND_WIDTH-1:PAGE_BITS];
   assign tlb_miss_o = !match_rdata[MR_VALID_BIT] || (match_vpn != req_vpn);

   // Permission bits for the current mode
   assign rd_ok = super_i ? xlate_rdata[TR_SRE_BIT] : xlate_rdata[TR_URE_BIT];
   assign wr_ok = super_i ? xlate_rdata[TR_SWE_BIT] : xlate_rdata[TR_UWE_BIT];
   assign page_fault_o = (store_i && !wr_ok) || (load_i && !rd_ok);

   // PPN joined with untranslated page offset
   assign paddr_o = {xlate_rdata[OPERAND_WIDTH-1:PAGE_BITS], match_vaddr_i[PAGE_BITS-1:0]};
   assign ci_o    = xlate_rdata[TR_CI_BIT];

   // Ack must land while the master still holds the access
   a_ack_in_window: assert property (@(posedge clk) disable iff (rst)
      spr_ack_o |-> (match_cs || xlate_cs));

   // Master keeps strobe up until it has seen ack
   a_stb_held: assert property (@(posedge clk) disable iff (rst)
      ((match_cs || xlate_cs) && !spr_ack_o) |=> spr_stb_i);

endmodule

`default_nettype wire

//--- lsu_xlate_stage.sv
// Load/store translate stage, one request per cycle
// Response is a single-cycle pulse one cycle after acceptance
// No response back-pressure
// Ready drops for the whole of any SPR strobe
`timescale 1ns/1ps
`default_nettype none

module lsu_xlate_stage (
   input  wire logic            clk,
   input  wire logic            rst,
   // Request
   input  wire logic            req_valid_i,
   input  wire dmmu_pkg::word_t req_vaddr_i,
   input  wire logic            req_load_i,
   input  wire logic            req_store_i,
   input  wire logic            req_super_i,
   output logic                 req_ready_o,
   // SPR strobe, owns RAM port when high
   input  wire logic            spr_stb_i,
   // To DMMU
   output dmmu_pkg::word_t      lookup_vaddr_o,
   output dmmu_pkg::word_t      match_vaddr_o,
   output logic                 load_o,
   output logic                 store_o,
   output logic                 super_o,
   // From DMMU, for match_vaddr_o
   input  wire logic            tlb_miss_i,
   input  wire logic            page_fault_i,
   input  wire dmmu_pkg::word_t paddr_i,
   input  wire logic            ci_i,
   // Response
   output logic                 resp_valid_o,
   output dmmu_pkg::word_t      resp_paddr_o,
   output logic                 resp_ci_o,
   output dmmu_pkg::exc_t       resp_exc_o
);

   import dmmu_pkg::*;

   logic  accept;
   logic  valid_q;   // Request in match cycle
   word_t vaddr_q;
   logic  load_q;
   logic  store_q;
   logic  super_q;

   assign req_ready_o = !spr_stb_i;  // SPR steals the lookup port
   assign accept      = req_valid_i && req_ready_o;

   // Unregistered index so RAM read lands in the next cycle
   assign lookup_vaddr_o = req_vaddr_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= accept;
      end
   end

   // Request payload, captured on accept only
   always_ff @(posedge clk) begin
      if (accept) begin
         vaddr_q <= req_vaddr_i;
         load_q  <= req_load_i;
         store_q <= req_store_i;
         super_q <= req_super_i;
      end
   end

   assign match_vaddr_o = vaddr_q;
   assign load_o        = load_q;
   assign store_o       = store_q;
   assign super_o       = super_q;

   // Response straight from the compare cycle
   assign resp_valid_o = valid_q;
   assign resp_paddr_o = paddr_i;
   assign resp_ci_o    = ci_i;

   // Miss first, a missed entry's permissions mean nothing
   always_comb begin
      if (tlb_miss_i) begin
         resp_exc_o = EXC_TLB_MISS;
      end else if (page_fault_i) begin
         resp_exc_o = EXC_PAGE_FAULT;
      end else begin
         resp_exc_o = EXC_NONE;
      end
   end

   // An op is a load or a store, never both
   a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
      resp_valid_o |-> !(load_q && store_q));

endmodule

`default_nettype wire

//--- dmmu_top.sv
// Translate stage plus DTLB, wiring only
// Response follows acceptance by exactly one cycle
// SPR master must hold strobe until ack
`timescale 1ns/1ps
`default_nettype none

module dmmu_top (
   input  wire logic                clk,
   input  wire logic                rst,
   // Request
   input  wire logic                req_valid_i,
   input  wire dmmu_pkg::word_t     req_vaddr_i,
   input  wire logic                req_load_i,
   input  wire logic                req_store_i,
   input  wire logic                req_super_i,
   output logic                     req_ready_o,
   // Response
   output logic                     resp_valid_o,
   output dmmu_pkg::word_t          resp_paddr_o,
   output logic                     resp_ci_o,
   output dmmu_pkg::exc_t           resp_exc_o,
   // SPR bus
   input  wire logic                spr_stb_i,
   input  wire logic                spr_we_i,
   input  wire dmmu_pkg::spr_addr_t spr_addr_i,
   input  wire dmmu_pkg::word_t     spr_wdata_i,
   output dmmu_pkg::word_t          spr_rdata_o,
   output logic                     spr_ack_o
);

   import dmmu_pkg::*;

   word_t lookup_vaddr;
   word_t match_vaddr;
   logic  op_load;
   logic  op_store;
   logic  op_super;
   word_t xl_paddr;
   logic  xl_ci;
   logic  xl_miss;
   logic  xl_fault;

   lsu_xlate_stage xlate (
      .clk            (clk),
      .rst            (rst),
      .req_valid_i    (req_valid_i),
      .req_vaddr_i    (req_vaddr_i),
      .req_load_i     (req_load_i),
      .req_store_i    (req_store_i),
      .req_super_i    (req_super_i),
      .req_ready_o    (req_ready_o),
      .spr_stb_i      (spr_stb_i),
      .lookup_vaddr_o (lookup_vaddr),
      .match_vaddr_o  (match_vaddr),
      .load_o         (op_load),
      .store_o        (op_store),
      .super_o        (op_super),
      .tlb_miss_i     (xl_miss),
      .page_fault_i   (xl_fault),
      .paddr_i        (xl_paddr),
      .ci_i           (xl_ci),
      .resp_valid_o   (resp_valid_o),
      .resp_paddr_o   (resp_paddr_o),
      .resp_ci_o      (resp_ci_o),
      .resp_exc_o     (resp_exc_o)
   );

   dmmu dmmu_i (
      .clk            (clk),
      .rst            (rst),
      .lookup_vaddr_i (lookup_vaddr),
      .match_vaddr_i  (match_vaddr),
      .load_i         (op_load),
      .store_i        (op_store),
      .super_i        (op_super),
      .paddr_o        (xl_paddr),
      .ci_o           (xl_ci),
      .tlb_miss_o     (xl_miss),
      .page_fault_o   (xl_fault),
      .spr_stb_i      (spr_stb_i),
      .spr_we_i       (spr_we_i),
      .spr_addr_i     (spr_addr_i),
      .spr_wdata_i    (spr_wdata_i),
      .spr_rdata_o    (spr_rdata_o),
      .spr_ack_o      (spr_ack_o)
   );

endmodule

`default_nettype wire

//--- tb_dmmu.sv
// Testbench for dmmu_top, driven from the script dmmu_tests.txt
// Run from the project root so the script path resolves
// Inputs change on the falling edge, outputs are sampled there too
// Stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_dmmu;

   import dmmu_pkg::*;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 3;
   localparam int MAX_BURST       = 8;   // Longest B group
   localparam int ACK_LIMIT       = 10;  // Cycles before a missing ack is an error
   localparam int CYCLES_PER_LINE = 20;  // Watchdog budget

   logic      clk;
   logic      rst;
   logic      req_valid_i;
   word_t     req_vaddr_i;
   logic      req_load_i;
   logic      req_store_i;
   logic      req_super_i;
   logic      req_ready_o;
   logic      resp_valid_o;
   word_t     resp_paddr_o;
   logic      resp_ci_o;
   exc_t      resp_exc_o;
   logic      spr_stb_i;
   logic      spr_we_i;
   spr_addr_t spr_addr_i;
   word_t     spr_wdata_i;
   word_t     spr_rdata_o;
   logic      spr_ack_o;

   string       lines[$];          // Whole script, read up front
   int          n_lines = 0;
   logic [31:0] lfsr = 32'h6edb;   // Idle gap source

   // Translate items of the current T, B or O line
   word_t t_vaddr [MAX_BURST];
   logic  t_st    [MAX_BURST];     // 1 store, 0 load
   logic  t_sup   [MAX_BURST];
   exc_t  t_exc   [MAX_BURST];
   word_t t_paddr [MAX_BURST];
   logic  t_ci    [MAX_BURST];

   dmmu_top dut (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_run();
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_exc(input string name, input exc_t got, input exc_t exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         stop_run();
      end
   endtask

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic void store_item(input int k, input word_t va, input int st,
                                      input int sup, input int ex, input word_t pa,
                                      input int ci);
      t_vaddr[k] = va;
      t_st[k]    = (st != 0);
      t_sup[k]   = (sup != 0);
      t_exc[k]   = exc_t'(ex[1:0]);  // 0 none, 1 miss, 2 fault
      t_paddr[k] = pa;
      t_ci[k]    = (ci != 0);
   endfunction

   task automatic parse_t(input string s, input int k);
      byte   kind;
      word_t va;
      word_t pa;
      int    st;
      int    sup;
      int    ex;
      int    ci;
      int    cnt;
      cnt = $sscanf(s, "%c %h %d %d %d %h %d", kind, va, st, sup, ex, pa, ci);
      if (cnt != 7 || kind != "T") begin
         abort_run("Malformed translate line in the test script");
      end
      store_item(k, va, st, sup, ex, pa, ci);
   endtask

   // 0 to 3 idle cycles, two LFSR bits
   task automatic idle_gap();
      logic [1:0] n;
      n[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      n[1] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      repeat (n) begin
         @(negedge clk);
         check_bit("resp_valid_o", resp_valid_o, 1'b0);  // Pulse must not linger
      end
   endtask

   task automatic drive_req(input int k);
      req_valid_i = 1'b1;
      req_vaddr_i = t_vaddr[k];
      req_load_i  = !t_st[k];
      req_store_i = t_st[k];
      req_super_i = t_sup[k];
   endtask

   task automatic check_resp(input int k);
      check_bit("resp_valid_o", resp_valid_o, 1'b1);
      check_word("resp_paddr_o", resp_paddr_o, t_paddr[k]);
      check_exc("resp_exc_o", resp_exc_o, t_exc[k]);
      check_bit("resp_ci_o", resp_ci_o, t_ci[k]);
   endtask

   // Items 0..n-1 back to back, response one cycle behind each accept
   task automatic run_burst(input int n);
      @(negedge clk);
      drive_req(0);
      for (int k = 1; k < n; k++) begin
         @(negedge clk);
         check_bit("req_ready_o", req_ready_o, 1'b1);  // Held over the accepting edge
         check_resp(k - 1);
         drive_req(k);
      end
      @(negedge clk);
      check_bit("req_ready_o", req_ready_o, 1'b1);
      check_resp(n - 1);
      req_valid_i = 1'b0;
   endtask

   // One SPR access; with offer set, item 0 is requested during the strobe
   task automatic spr_access(input logic we, input spr_addr_t addr, input word_t data,
                             input logic offer);
      int cycles;
      cycles = 0;
      @(negedge clk);
      spr_stb_i   = 1'b1;
      spr_we_i    = we;
      spr_addr_i  = addr;
      spr_wdata_i = we ? data : '0;
      if (offer) begin
         drive_req(0);
      end
      do begin
         @(negedge clk);
         cycles++;
         check_bit("req_ready_o", req_ready_o, 1'b0);    // Port belongs to SPR
         check_bit("resp_valid_o", resp_valid_o, 1'b0);
      end while (!spr_ack_o && cycles < ACK_LIMIT);
      if (!spr_ack_o) begin
         abort_run("SPR access was never acknowledged");
      end
      if (cycles != 1) begin
         abort_run("SPR ack did not come in the second strobe cycle");
      end
      if (!we) begin
         check_word("spr_rdata_o", spr_rdata_o, data);
      end
      @(negedge clk);                                 // Master saw ack at this edge
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
      check_bit("spr_ack_o", spr_ack_o, 1'b0);        // Single ack pulse
      if (offer) begin
         @(negedge clk);
         check_resp(0);                               // Lookup saw the new entry
         req_valid_i = 1'b0;
      end
   endtask

   // Watchdog, budget from script length
   initial begin
      wait (n_lines > 0);
      #((n_lines * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
      abort_run("Watchdog timeout, the test script did not finish in time");
   end

   initial begin
      string     line;
      byte       kind;
      spr_addr_t a;
      word_t     d;
      word_t     va;
      word_t     pa;
      int        fd;
      int        cnt;
      int        n;
      int        st;
      int        sup;
      int        ex;
      int        ci;
      rst         = 1'b1;
      req_valid_i = 1'b0;
      req_vaddr_i = '0;
      req_load_i  = 1'b0;
      req_store_i = 1'b0;
      req_super_i = 1'b0;
      spr_stb_i   = 1'b0;
      spr_we_i    = 1'b0;
      spr_addr_i  = '0;
      spr_wdata_i = '0;
      fd = $fopen("dmmu_tests.txt", "r");
      if (fd == 0) begin
         abort_run("Cannot open dmmu_tests.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0) begin
            lines.push_back(line);
         end
      end
      $fclose(fd);
      n_lines = lines.size();                         // Starts the watchdog
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      check_bit("req_ready_o", req_ready_o, 1'b1);
      check_bit("resp_valid_o", resp_valid_o, 1'b0);
      check_bit("spr_ack_o", spr_ack_o, 1'b0);
      for (int i = 0; i < lines.size(); i++) begin
         line = lines[i];
         cnt  = $sscanf(line, "%c", kind);
         if (cnt != 1 || kind == "#" || kind == " " || kind == "\n") begin
            continue;                                 // Comment or blank
         end
         case (kind)
            "W", "R": begin
               cnt = $sscanf(line, "%c %h %h", kind, a, d);
               if (cnt != 3) begin
                  abort_run("Malformed SPR line in the test script");
               end
               spr_access(kind == "W", a, d, 1'b0);
            end
            "T": begin
               parse_t(line, 0);
               run_burst(1);
            end
            "B": begin
               cnt = $sscanf(line, "%c %d", kind, n);
               if (cnt != 2 || n < 1 || n > MAX_BURST || i + n >= lines.size()) begin
                  abort_run("Malformed burst line in the test script");
               end
               for (int k = 0; k < n; k++) begin
                  i++;
                  parse_t(lines[i], k);
               end
               run_burst(n);
            end
            "O": begin
               cnt = $sscanf(line, "%c %h %h %h %d %d %d %h %d",
                             kind, a, d, va, st, sup, ex, pa, ci);
               if (cnt != 9) begin
                  abort_run("Malformed offered-request line in the test script");
               end
               store_item(0, va, st, sup, ex, pa, ci);
               spr_access(1'b1, a, d, 1'b1);
            end
            default: abort_run("Unknown line kind in the test script");
         endcase
         idle_gap();
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- dmmu_tests.txt
# W spraddr wdata | R spraddr rdata | B count, then count T lines back to back
# T vaddr store super exc paddr ci (exc 0 none 1 miss 2 fault) | O spraddr wdata + T fields
W 0A01 00002001
W 0A81 800003C0
W 0A02 40004001
W 0A82 00124042
W 0A03 00006001
W 0A83 7FFFE180
W 0A04 00008000
W 0A84 00000000
R 0A01 00002001
R 0A82 00124042
R 0A83 7FFFE180
R 0A04 00008000
T 00002ABC 0 0 0 80000ABC 0
T 00002ABC 1 0 0 80000ABC 0
T 40004567 0 0 0 00124567 1
T 40004567 1 0 2 00124567 1
T 40004567 0 1 2 00124567 1
T 00006100 1 0 0 7FFFE100 0
T 00006100 0 1 0 7FFFE100 0
T 00006100 1 1 2 7FFFE100 0
T 00006100 0 0 2 7FFFE100 0
T 00008010 1 0 1 00000010 0
T 40084123 1 0 1 00124123 1
B 3
T 00003FFC 1 1 0 80001FFC 0
T 40005008 0 0 0 00125008 1
T 00007000 1 1 2 7FFFF000 0
O 0A81 0ABCC042 00002010 0 0 0 0ABCC010 1
T 00002010 1 0 2 0ABCC010 1
R 0A81 0ABCC042

//--- tb.f
dmmu_pkg.sv
tlb_ram.sv
dmmu.sv
lsu_xlate_stage.sv
dmmu_top.sv
tb_dmmu.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from the project root, judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_dmmu \
   && ./obj_dir/Vtb_dmmu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
